// File: rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine word width, addresses use the same width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural register count
`define RV_NUM_REGS 32

// register index width, log2 of the register count
`define RV_REG_AW 5

`endif

// File: rv_pkg.sv
package rv_pkg;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N  // system and unknown opcodes, treated as nop
    } inst_fmt_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // encodings follow funct3 of the branch opcode
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_cond_t;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101
    } mem_size_t;

endpackage

// File: rv_fetch.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               reset,
    input  logic               jump_en,
    input  logic [`RV_XLEN-1:0] jump_target,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] snpc
);

    logic [`RV_XLEN-1:0] dnpc;

    assign snpc = pc + `RV_XLEN'd4;  // sequential pc, also the link value
    assign dnpc = jump_en ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

// File: rv_decode.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_decode import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0]   inst,
    output opcode_t               opcode,
    output logic [2:0]            funct3,
    output logic                  funct7_b5,
    output logic [`RV_REG_AW-1:0] rd,
    output logic [`RV_REG_AW-1:0] rs1,
    output logic [`RV_REG_AW-1:0] rs2,
    output inst_fmt_t             fmt,
    output logic [`RV_XLEN-1:0]   imm
);

    assign opcode    = opcode_t'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign funct7_b5 = inst[30];  // sub / sra select
    assign rd        = inst[11:7];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];

    always_comb begin
        case (opcode)
            OPC_OP: fmt = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt = FMT_I;
            OPC_STORE: fmt = FMT_S;
            OPC_BRANCH: fmt = FMT_B;
            OPC_LUI, OPC_AUIPC: fmt = FMT_U;
            OPC_JAL: fmt = FMT_J;
            default: fmt = FMT_N;  // system opcode lands here too
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            FMT_S: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            FMT_B: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            FMT_U: begin
                imm = {inst[31:12], 12'h000};  // upper 20 bits
            end
            FMT_J: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // R and N carry no immediate
            end
        endcase
    end

endmodule

// File: rv_regfile.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired, whatever the array holds
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

// File: rv_alu.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_alu import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  alu_op_t             op,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];  // only the low bits count for shifts
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;  // keeps the sign
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// File: rv_execute.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_execute import rv_pkg::*; (
    input  opcode_t             opcode,
    input  inst_fmt_t           fmt,
    input  logic [2:0]          funct3,
    input  logic                funct7_b5,
    input  logic [`RV_XLEN-1:0] src1,
    input  logic [`RV_XLEN-1:0] src2,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic                jump_en,
    output logic [`RV_XLEN-1:0] jump_target
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    alu_op_t             alu_op;
    logic                taken;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (fmt)
            FMT_B, FMT_J: alu_a = pc;  // pc-relative targets
            FMT_U: alu_a = (opcode == OPC_LUI) ? '0 : pc;
            default: alu_a = src1;
        endcase
        alu_b = (fmt == FMT_R) ? src2 : imm;
    end

    always_comb begin
        alu_op = ALU_ADD;  // address and target arithmetic
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                3'b000: alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (branch_cond_t'(funct3))
            BR_BEQ:  taken = (src1 == src2);
            BR_BNE:  taken = (src1 != src2);
            BR_BLT:  taken = ($signed(src1) < $signed(src2));
            BR_BGE:  taken = ($signed(src1) >= $signed(src2));
            BR_BLTU: taken = (src1 < src2);
            BR_BGEU: taken = (src1 >= src2);
            default: taken = 1'b0;  // reserved encodings fall through
        endcase
    end

    assign jump_en = (opcode == OPC_BRANCH && taken) || opcode == OPC_JAL || opcode == OPC_JALR;
    assign jump_target = (opcode == OPC_JALR) ? {alu_result[`RV_XLEN-1:1], 1'b0} : alu_result;

endmodule

// File: rv_mem_wb.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_mem_wb import rv_pkg::*; (
    input  logic                  reset,
    input  opcode_t               opcode,
    input  logic [2:0]            funct3,
    input  logic [`RV_REG_AW-1:0] rd,
    input  logic [`RV_XLEN-1:0]   alu_result,
    input  logic [`RV_XLEN-1:0]   src2,
    input  logic [`RV_XLEN-1:0]   snpc,
    input  logic [`RV_XLEN-1:0]   dmem_rdata,
    output logic [`RV_XLEN-1:0]   dmem_addr,
    output logic                  dmem_we,
    output logic [3:0]            dmem_wstrb,
    output logic [`RV_XLEN-1:0]   dmem_wdata,
    output logic                  gpr_we,
    output logic [`RV_REG_AW-1:0] gpr_waddr,
    output logic [`RV_XLEN-1:0]   gpr_wdata
);

    mem_size_t           size;
    logic [4:0]          lane_shift;
    logic [3:0]          strb_base;
    logic [`RV_XLEN-1:0] rdata_lane;
    logic [`RV_XLEN-1:0] load_data;
    logic                wb_en;

    assign size       = mem_size_t'(funct3);
    assign lane_shift = {alu_result[1:0], 3'b000};  // byte offset in bits
    assign dmem_addr  = alu_result;

    always_comb begin
        case (size)
            MEM_BYTE: strb_base = 4'b0001;
            MEM_HALF: strb_base = 4'b0011;
            MEM_WORD: strb_base = 4'b1111;
            default:  strb_base = 4'b0000;  // no such store
        endcase
    end

    assign dmem_wstrb = strb_base << alu_result[1:0];
    assign dmem_wdata = src2 << lane_shift;
    assign dmem_we    = (opcode == OPC_STORE) && (|strb_base) && !reset;

    assign rdata_lane = dmem_rdata >> lane_shift;  // addressed lane to bit 0

    always_comb begin
        case (size)
            MEM_BYTE:   load_data = {{24{rdata_lane[7]}}, rdata_lane[7:0]};
            MEM_HALF:   load_data = {{16{rdata_lane[15]}}, rdata_lane[15:0]};
            MEM_WORD:   load_data = rdata_lane;
            MEM_BYTE_U: load_data = {24'h00_0000, rdata_lane[7:0]};
            MEM_HALF_U: load_data = {16'h0000, rdata_lane[15:0]};
            default:    load_data = '0;
        endcase
    end

    always_comb begin
        wb_en     = 1'b1;
        gpr_wdata = alu_result;
        case (opcode)
            OPC_JAL, OPC_JALR: gpr_wdata = snpc;  // link
            OPC_LOAD: gpr_wdata = load_data;
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: gpr_wdata = alu_result;
            default: wb_en = 1'b0;  // stores, branches, nops
        endcase
    end

    assign gpr_we    = wb_en && (rd != '0) && !reset;
    assign gpr_waddr = rd;

endmodule

// File: rv_core.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic [`RV_XLEN-1:0]   imem_rdata,
    output logic [`RV_XLEN-1:0]   dmem_addr,
    output logic                  dmem_we,
    output logic [3:0]            dmem_wstrb,
    output logic [`RV_XLEN-1:0]   dmem_wdata,
    input  logic [`RV_XLEN-1:0]   dmem_rdata,
    output logic                  gpr_we,
    output logic [`RV_REG_AW-1:0] gpr_waddr,
    output logic [`RV_XLEN-1:0]   gpr_wdata
);

    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   snpc;
    logic                  jump_en;
    logic [`RV_XLEN-1:0]   jump_target;
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    inst_fmt_t             fmt;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic [`RV_XLEN-1:0]   alu_result;

    assign imem_addr = pc;  // rom answers in the same cycle

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    rv_decode u_decode (
        .inst      (imem_rdata),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_b5 (funct7_b5),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .fmt       (fmt),
        .imm       (imm)
    );

    // write side is the retire port itself
    rv_regfile u_regfile (
        .clk    (clk),
        .we     (gpr_we),
        .waddr  (gpr_waddr),
        .wdata  (gpr_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute u_execute (
        .opcode      (opcode),
        .fmt         (fmt),
        .funct3      (funct3),
        .funct7_b5   (funct7_b5),
        .src1        (rdata1),
        .src2        (rdata2),
        .imm         (imm),
        .pc          (pc),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    rv_mem_wb u_mem_wb (
        .reset      (reset),
        .opcode     (opcode),
        .funct3     (funct3),
        .rd         (rd),
        .alu_result (alu_result),
        .src2       (rdata2),
        .snpc       (snpc),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wdata (dmem_wdata),
        .gpr_we     (gpr_we),
        .gpr_waddr  (gpr_waddr),
        .gpr_wdata  (gpr_wdata)
    );

endmodule

// File: rv_core_properties.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module rv_core_properties (
    input logic                  clk,
    input logic                  reset,
    input logic [`RV_XLEN-1:0]   imem_addr,
    input logic                  dmem_we,
    input logic [3:0]            dmem_wstrb,
    input logic                  gpr_we,
    input logic [`RV_REG_AW-1:0] gpr_waddr
);

    assert property (@(posedge clk) dmem_we |-> dmem_wstrb != 4'b0000)
        else $error("store with an empty strobe");

    assert property (@(posedge clk) gpr_we |-> gpr_waddr != '0)
        else $error("register write aimed at x0");

    // pc is undefined until the first reset edge
    assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else $error("misaligned fetch address");

    assert property (@(posedge clk) reset |-> !dmem_we && !gpr_we)
        else $error("write enable high during reset");

endmodule

// File: tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int NUM_CYCLES   = 600;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic [`RV_XLEN-1:0]   imem_addr, imem_rdata;
    logic [`RV_XLEN-1:0]   dmem_addr, dmem_wdata, dmem_rdata;
    logic                  dmem_we;
    logic [3:0]            dmem_wstrb;
    logic                  gpr_we;
    logic [`RV_REG_AW-1:0] gpr_waddr;
    logic [`RV_XLEN-1:0]   gpr_wdata;

    logic [`RV_XLEN-1:0] rom [256];
    logic [`RV_XLEN-1:0] ram [256];
    logic [`RV_XLEN-1:0] shadow_ram [256];
    logic [`RV_XLEN-1:0] shadow_regs [`RV_NUM_REGS];
    logic [`RV_XLEN-1:0] shadow_pc;
    logic [31:0]         rng;

    rv_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .gpr_we     (gpr_we),
        .gpr_waddr  (gpr_waddr),
        .gpr_wdata  (gpr_wdata)
    );

    bind rv_core rv_core_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .dmem_we    (dmem_we),
        .dmem_wstrb (dmem_wstrb),
        .gpr_we     (gpr_we),
        .gpr_waddr  (gpr_waddr)
    );

    assign imem_rdata = rom[imem_addr[9:2]];  // same-cycle rom
    assign dmem_rdata = ram[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            ram[dmem_addr[9:2]] <= (ram[dmem_addr[9:2]] & ~lane_mask(dmem_wstrb))
                                 | (dmem_wdata & lane_mask(dmem_wstrb));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // one random instruction from two draws
    function automatic logic [31:0] make_inst(input logic [31:0] r, input logic [31:0] s);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        rd   = r[4:0];
        rs1  = r[9:5];
        rs2  = r[14:10];
        f3   = r[17:15];
        boff = {6'd0, s[4:0], 2'b00} + 13'd4;  // forward 4 to 128
        joff = {14'd0, s[4:0], 2'b00} + 21'd4;
        case (r[31:28])
            4'd0, 4'd1: begin
                imm = {((f3 == 3'd0 || f3 == 3'd5) && s[12]) ? 7'b0100000 : 7'd0, rs2};
                return {imm, rs1, f3, rd, OPC_OP};
            end
            4'd2, 4'd3: begin
                imm = s[11:0];
                if (f3 == 3'd1) imm = {7'd0, s[4:0]};
                if (f3 == 3'd5) imm = {1'b0, s[12], 5'd0, s[4:0]};  // srli or srai
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            4'd4: return {s[31:12], rd, OPC_LUI};
            4'd5: return {s[31:12], rd, OPC_AUIPC};
            4'd6, 4'd7: begin
                if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
                imm = {2'b00, s[9:0] & ~((10'd1 << f3[1:0]) - 10'd1)};  // size aligned
                return {imm, 5'd0, f3, rd, OPC_LOAD};
            end
            4'd8, 4'd9: begin
                f3  = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                imm = {2'b00, s[9:0] & ~((10'd1 << f3[1:0]) - 10'd1)};
                return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OPC_STORE};
            end
            4'd10, 4'd11: begin
                if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]};  // skip reserved conditions
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            end
            4'd12: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            4'd13: begin
                imm = {2'b00, s[9:2], 1'b0, s[0]};  // odd target now and then
                return {imm, 5'd0, 3'd0, rd, OPC_JALR};
            end
            4'd14: return {s[31:7], 7'b1110011};  // system opcode
            default: return {s[31:7], 7'b0001011};  // custom opcode, unknown to the core
        endcase
    endfunction

    // one architectural step of the shadow machine
    function automatic void predict_step(
        output logic                  wr_en,
        output logic [`RV_REG_AW-1:0] wr_idx,
        output logic [`RV_XLEN-1:0]   wr_val,
        output logic                  st_en,
        output logic [`RV_XLEN-1:0]   st_addr,
        output logic [3:0]            st_strb,
        output logic [`RV_XLEN-1:0]   st_data,
        output logic [`RV_XLEN-1:0]   next_pc
    );
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opb;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] lane;
        logic [4:0]  sh;
        logic [2:0]  f3;
        logic        taken;
        inst    = rom[shadow_pc[9:2]];
        f3      = inst[14:12];
        a       = shadow_regs[inst[19:15]];
        b       = shadow_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        wr_en   = 1'b0;
        wr_idx  = inst[11:7];
        wr_val  = '0;
        st_en   = 1'b0;
        st_addr = '0;
        st_strb = '0;
        st_data = '0;
        next_pc = shadow_pc + 32'd4;
        case (opcode_t'(inst[6:0]))
            OPC_OP, OPC_OP_IMM: begin
                wr_en = 1'b1;
                opb   = (inst[6:0] == OPC_OP) ? b : imm_i;
                sh    = opb[4:0];
                case (f3)
                    3'd0: wr_val = (inst[6:0] == OPC_OP && inst[30]) ? a - opb : a + opb;
                    3'd1: wr_val = a << sh;
                    3'd2: wr_val = {31'd0, $signed(a) < $signed(opb)};
                    3'd3: wr_val = {31'd0, a < opb};
                    3'd4: wr_val = a ^ opb;
                    3'd5: begin
                        if (inst[30]) wr_val = $signed(a) >>> sh;
                        else wr_val = a >> sh;
                    end
                    3'd6: wr_val = a | opb;
                    default: wr_val = a & opb;
                endcase
            end
            OPC_LUI: begin
                wr_en  = 1'b1;
                wr_val = {inst[31:12], 12'h000};
            end
            OPC_AUIPC: begin
                wr_en  = 1'b1;
                wr_val = shadow_pc + {inst[31:12], 12'h000};
            end
            OPC_JAL: begin
                wr_en   = 1'b1;
                wr_val  = shadow_pc + 32'd4;
                next_pc = shadow_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                wr_en   = 1'b1;
                wr_val  = shadow_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                case (branch_cond_t'(f3))
                    BR_BEQ:  taken = a == b;
                    BR_BNE:  taken = a != b;
                    BR_BLT:  taken = $signed(a) < $signed(b);
                    BR_BGE:  taken = $signed(a) >= $signed(b);
                    BR_BLTU: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) begin
                    next_pc = shadow_pc
                        + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                wr_en = 1'b1;
                addr  = a + imm_i;
                lane  = shadow_ram[addr[9:2]] >> (8 * addr[1:0]);
                case (mem_size_t'(f3))
                    MEM_BYTE:   wr_val = {{24{lane[7]}}, lane[7:0]};
                    MEM_HALF:   wr_val = {{16{lane[15]}}, lane[15:0]};
                    MEM_BYTE_U: wr_val = {24'd0, lane[7:0]};
                    MEM_HALF_U: wr_val = {16'd0, lane[15:0]};
                    default:    wr_val = lane;
                endcase
            end
            OPC_STORE: begin
                st_en   = 1'b1;
                st_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                case (mem_size_t'(f3))
                    MEM_BYTE: st_strb = 4'b0001 << st_addr[1:0];
                    MEM_HALF: st_strb = 4'b0011 << st_addr[1:0];
                    default:  st_strb = 4'b1111;
                endcase
                st_data = (b << (8 * st_addr[1:0])) & lane_mask(st_strb);
                shadow_ram[st_addr[9:2]] = (shadow_ram[st_addr[9:2]] & ~lane_mask(st_strb))
                                         | st_data;
            end
            default: ;  // retires as a nop
        endcase
        if (wr_idx == '0) wr_en = 1'b0;  // x0 never written
        if (wr_en) shadow_regs[wr_idx] = wr_val;
        shadow_pc = next_pc;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [`RV_XLEN-1:0] got, exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input logic [`RV_REG_AW-1:0] got, exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_strobe(input string name, input logic [3:0] got, exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : setup
        logic [31:0] r;
        logic [31:0] boot_word;
        reset     = 1'b1;
        rng       = 32'h28cd8475;
        shadow_pc = `RV_RESET_PC;
        for (int i = 0; i < `RV_NUM_REGS; i++) shadow_regs[i] = '0;
        for (int i = 0; i < 256; i++) begin
            ram[i]        = 32'h9e37_79b1 * (i + 1);  // distinct per word address
            shadow_ram[i] = ram[i];
            rng = xorshift32(rng);
            r   = rng;
            rng = xorshift32(rng);
            if (i < `RV_NUM_REGS - 1) rom[i] = {r[31:12], 5'(i + 1), OPC_LUI};  // x1..x31 defined
            else rom[i] = make_inst(r, rng);
        end
        boot_word = rom[0];
        rom[0]    = {12'h000, 5'd0, 3'd2, 5'd0, OPC_STORE};  // sw x0 at the reset pc
        repeat (RESET_CYCLES / 2) @(posedge clk);
        #(DRIVE_DELAY);
        rom[0] = boot_word;  // lui x1 for the rest of reset and the run
        repeat (RESET_CYCLES / 2) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
    end

    initial begin : compare_proc
        logic                  e_we;
        logic [`RV_REG_AW-1:0] e_rd;
        logic [`RV_XLEN-1:0]   e_val;
        logic                  e_st;
        logic [`RV_XLEN-1:0]   e_addr;
        logic [3:0]            e_strb;
        logic [`RV_XLEN-1:0]   e_data;
        logic [`RV_XLEN-1:0]   e_pc;
        int                    checked;
        checked = 0;
        while (checked < NUM_CYCLES) begin
            @(negedge clk);  // outputs settled mid-cycle
            if (reset) begin
                compare_flag("gpr_we", gpr_we, 1'b0);
                compare_flag("dmem_we", dmem_we, 1'b0);
            end else begin
                compare_word("imem_addr", imem_addr, shadow_pc);
                predict_step(e_we, e_rd, e_val, e_st, e_addr, e_strb, e_data, e_pc);
                compare_flag("gpr_we", gpr_we, e_we);
                if (e_we) begin
                    compare_reg("gpr_waddr", gpr_waddr, e_rd);
                    compare_word("gpr_wdata", gpr_wdata, e_val);
                end
                compare_flag("dmem_we", dmem_we, e_st);
                if (e_st) begin
                    compare_word("dmem_addr", dmem_addr, e_addr);
                    compare_strobe("dmem_wstrb", dmem_wstrb, e_strb);
                    compare_word("dmem_wdata", dmem_wdata & lane_mask(e_strb), e_data);
                end
                checked++;
            end
        end
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all cycles were checked");
    end

endmodule

// File: vlog.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_regfile.sv
      - rv_alu.sv
      - rv_execute.sv
      - rv_mem_wb.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - rv_core_properties.sv
      - tb_rv_core.sv
